/* hw/rv_core.sv */
`timescale 1ns/100ps
`include "rv_macros.svh"

module rv_core import rv_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  inst_u               inst,
    input  logic                inst_valid,
    output logic                inst_ready,
    output wb_t                 wb,
    output logic                halted,
    output logic [`RV_XLEN-1:0] pc
);

    logic                  fire;
    logic [`RV_REG_AW-1:0] raddr1;
    logic [`RV_REG_AW-1:0] raddr2;
    logic [`RV_XLEN-1:0]   rdata1;
    logic [`RV_XLEN-1:0]   rdata2;
    dec_t                  dec;
    logic                  wen;
    logic [`RV_REG_AW-1:0] waddr;
    logic [`RV_XLEN-1:0]   wdata;

    rv_ifu i_rv_ifu (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .halted     (halted),
        .inst_ready (inst_ready),
        .fire       (fire),
        .pc         (pc)
    );

    rv_idu i_rv_idu (
        .inst   (inst),
        .pc     (pc),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .dec    (dec)
    );

    // register file sits next to the decoder it feeds
    rv_regfile i_rv_regfile (
        .clk    (clk),
        .rst_n  (rst_n),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .wen    (wen),
        .waddr  (waddr),
        .wdata  (wdata)
    );

    rv_exu i_rv_exu (
        .clk    (clk),
        .rst_n  (rst_n),
        .fire   (fire),
        .dec    (dec),
        .wen    (wen),
        .waddr  (waddr),
        .wdata  (wdata),
        .wb     (wb),
        .halted (halted)
    );

endmodule

/* hw/rv_exu.sv */
`timescale 1ns/100ps
`include "rv_macros.svh"

module rv_exu import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  fire,
    input  dec_t                  dec,
    output logic                  wen,
    output logic [`RV_REG_AW-1:0] waddr,
    output logic [`RV_XLEN-1:0]   wdata,
    output wb_t                   wb,
    output logic                  halted
);

    logic [`RV_XLEN-1:0]   result;
    logic                  writes;
    logic                  wb_valid_q;
    logic [`RV_REG_AW-1:0] wb_rd_q;
    logic [`RV_XLEN-1:0]   wb_value_q;
    logic                  halted_q;

    always_comb begin
        case (dec.cmd)
            ADD:     result = dec.src1 + dec.src2;
            PASS:    result = dec.src1;
            default: result = '0;
        endcase
    end

    assign writes = (dec.cmd == ADD) || (dec.cmd == PASS);

    assign wen   = fire & writes;
    assign waddr = dec.rd;
    assign wdata = result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid_q <= 1'b0;
            halted_q   <= 1'b0;
        end else begin
            wb_valid_q <= wen; // one-cycle report
            if (fire && dec.cmd == HALT) begin
                halted_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wen) begin
            wb_rd_q    <= dec.rd;
            wb_value_q <= result;
        end
    end

    assign wb.valid = wb_valid_q;
    assign wb.rd    = wb_rd_q;
    assign wb.value = wb_value_q;
    assign halted   = halted_q;

endmodule

/* hw/rv_idu.sv */
`timescale 1ns/100ps
`include "rv_macros.svh"

module rv_idu import rv_pkg::*; (
    input  inst_u                 inst,
    input  logic [`RV_XLEN-1:0]   pc,
    input  logic [`RV_XLEN-1:0]   rdata1,
    input  logic [`RV_XLEN-1:0]   rdata2,
    output logic [`RV_REG_AW-1:0] raddr1,
    output logic [`RV_REG_AW-1:0] raddr2,
    output dec_t                  dec
);

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_u;
    logic                rs1_en;
    logic                rs2_en;
    logic                rd_en;
    exu_cmd_t            cmd;
    logic [`RV_XLEN-1:0] src1;
    logic [`RV_XLEN-1:0] src2;

    assign opcode = inst.r.opcode;
    assign funct3 = inst.r.funct3;

    assign imm_i = {{(`RV_XLEN-12){inst.i.imm12[11]}}, inst.i.imm12};
    assign imm_u = {inst.u.imm20, 12'b0};

    always_comb begin
        cmd    = NOP;
        src1   = '0;
        src2   = '0;
        rs1_en = 1'b0;
        rs2_en = 1'b0;
        rd_en  = 1'b0;
        case (opcode)
            `RV_OP_IMM: begin
                if (funct3 == 3'b000) begin // addi
                    cmd    = ADD;
                    src1   = rdata1;
                    src2   = imm_i;
                    rs1_en = 1'b1;
                    rd_en  = 1'b1;
                end
            end
            `RV_OP_REG: begin
                if (funct3 == 3'b000 && inst.r.funct7 == 7'b0) begin // add
                    cmd    = ADD;
                    src1   = rdata1;
                    src2   = rdata2;
                    rs1_en = 1'b1;
                    rs2_en = 1'b1;
                    rd_en  = 1'b1;
                end
            end
            `RV_OP_LUI: begin
                cmd   = PASS;
                src1  = imm_u;
                rd_en = 1'b1;
            end
            `RV_OP_AUIPC: begin
                cmd   = ADD;
                src1  = pc;
                src2  = imm_u;
                rd_en = 1'b1;
            end
            `RV_OP_SYSTEM: begin
                // ebreak halts while ecall and csr ops decode as nop
                if (funct3 == 3'b000 && inst.i.imm12 == `RV_IMM12_EBREAK &&
                    inst.i.rs1 == '0 && inst.i.rd == '0) begin
                    cmd = HALT;
                end
            end
            default: begin
                cmd = NOP;
            end
        endcase
    end

    // unused operands read x0
    assign raddr1 = rs1_en ? inst.r.rs1 : '0;
    assign raddr2 = rs2_en ? inst.r.rs2 : '0;

    assign dec.cmd  = cmd;
    assign dec.src1 = src1;
    assign dec.src2 = src2;
    assign dec.rd   = rd_en ? inst.r.rd : '0;

endmodule

/* hw/rv_ifu.sv */
`timescale 1ns/100ps
`include "rv_macros.svh"

module rv_ifu (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                inst_valid,
    input  logic                halted,
    output logic                inst_ready,
    output logic                fire,
    output logic [`RV_XLEN-1:0] pc
);

    logic [`RV_XLEN-1:0] pc_q;

    // nothing is taken once ebreak has retired
    assign inst_ready = ~halted;
    assign fire       = inst_valid & inst_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= `RV_RESET_PC;
        end else if (fire) begin
            pc_q <= pc_q + `RV_XLEN'd4;
        end
    end

    assign pc = pc_q;

endmodule

/* hw/rv_macros.svh */
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// machine word and register file geometry
`define RV_XLEN     32
`define RV_REG_AW   5
`define RV_REG_NUM  32

`define RV_RESET_PC 32'h8000_0000

// major opcodes handled by the decoder
`define RV_OP_IMM    7'b0010011
`define RV_OP_REG    7'b0110011
`define RV_OP_LUI    7'b0110111
`define RV_OP_AUIPC  7'b0010111
`define RV_OP_SYSTEM 7'b1110011

`define RV_IMM12_EBREAK 12'h001

`endif

/* hw/rv_pkg.sv */
`include "rv_macros.svh"

package rv_pkg;

    typedef struct packed {
        logic [6:0]              funct7;
        logic [`RV_REG_AW-1:0]   rs2;
        logic [`RV_REG_AW-1:0]   rs1;
        logic [2:0]              funct3;
        logic [`RV_REG_AW-1:0]   rd;
        logic [6:0]              opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]             imm12;
        logic [`RV_REG_AW-1:0]   rs1;
        logic [2:0]              funct3;
        logic [`RV_REG_AW-1:0]   rd;
        logic [6:0]              opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [19:0]             imm20;
        logic [`RV_REG_AW-1:0]   rd;
        logic [6:0]              opcode;
    } u_fmt_t;

    // one instruction word in three layouts
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        u_fmt_t u;
    } inst_u;

    typedef enum logic [1:0] {
        NOP  = 2'd0,
        ADD  = 2'd1,
        PASS = 2'd2, // result is src1
        HALT = 2'd3
    } exu_cmd_t;

    typedef struct packed {
        exu_cmd_t                cmd;
        logic [`RV_XLEN-1:0]     src1;
        logic [`RV_XLEN-1:0]     src2;
        logic [`RV_REG_AW-1:0]   rd;
    } dec_t;

    typedef struct packed {
        logic                    valid;
        logic [`RV_REG_AW-1:0]   rd;
        logic [`RV_XLEN-1:0]     value;
    } wb_t;

endpackage

/* hw/rv_regfile.sv */
`timescale 1ns/100ps
`include "rv_macros.svh"

module rv_regfile (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`RV_REG_AW-1:0] raddr1,
    input  logic [`RV_REG_AW-1:0] raddr2,
    output logic [`RV_XLEN-1:0]   rdata1,
    output logic [`RV_XLEN-1:0]   rdata2,
    input  logic                  wen,
    input  logic [`RV_REG_AW-1:0] waddr,
    input  logic [`RV_XLEN-1:0]   wdata
);

    // no storage for x0
    logic [`RV_XLEN-1:0] regs [1:`RV_REG_NUM-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 1; k < `RV_REG_NUM; k++) begin
                regs[k] <= '0;
            end
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/100ps -f tb.f --top-module rv_core_tb

out=$(./obj_dir/Vrv_core_tb 2>&1 || true)
echo "$out"

if echo "$out" | grep -qx "Everything OK"; then
    exit 0
fi
exit 1

/* tb.f */
+incdir+hw
hw/rv_pkg.sv
hw/rv_ifu.sv
hw/rv_idu.sv
hw/rv_regfile.sv
hw/rv_exu.sv
hw/rv_core.sv
test/rv_core_tb.sv

/* test/rv_core_tb.sv */
`timescale 1ns/100ps
`include "rv_macros.svh"

module rv_core_tb import rv_pkg::*; ();

    localparam int prog_len   = 40;
    localparam int max_cycles = 400; // about ten times the program length

    typedef enum logic [2:0] {k_addi, k_add, k_lui, k_auipc, k_bad, k_ebreak} kind_t;

    typedef struct packed {
        kind_t       kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [19:0] imm; // addi takes the low 12 bits
    } prog_op_t;

    logic                clk;
    logic                rst_n;
    inst_u               inst;
    logic                inst_valid;
    logic                inst_ready;
    wb_t                 wb;
    logic                halted;
    logic [`RV_XLEN-1:0] pc;
    prog_op_t            prog [prog_len];
    logic [31:0]         model_regs [32];
    int                  accepted;
    int                  cycles;
    logic                drive_done;

    rv_core i_rv_core (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        assert (act === exp) else begin
            stop_with_failure($sformatf("mismatch at %0t: %s expected %h, actual %h",
                $time, name, exp, act));
        end
    endtask

    // RV32I encodings
    function automatic logic [31:0] op_word(input prog_op_t op);
        logic [31:0] w;
        case (op.kind)
            k_addi:  w = {op.imm[11:0], op.rs1, 3'b000, op.rd, 7'b0010011};
            k_add:   w = {7'b0, op.rs2, op.rs1, 3'b000, op.rd, 7'b0110011};
            k_lui:   w = {op.imm, op.rd, 7'b0110111};
            k_auipc: w = {op.imm, op.rd, 7'b0010111};
            k_bad:   w = {op.imm, op.rd, op.rs2[0] ? 7'b1101111 : 7'b0000011}; // jal or load
            default: w = 32'h0010_0073; // ebreak
        endcase
        return w;
    endfunction

    function automatic wb_t predict_wb(input prog_op_t op, input logic [31:0] op_pc);
        wb_t res;
        res.valid = 1'b1;
        res.rd    = op.rd;
        res.value = '0;
        case (op.kind)
            k_addi:  res.value = model_regs[op.rs1] + {{20{op.imm[11]}}, op.imm[11:0]};
            k_add:   res.value = model_regs[op.rs1] + model_regs[op.rs2];
            k_lui:   res.value = {op.imm, 12'b0};
            k_auipc: res.value = op_pc + {op.imm, 12'b0};
            default: res.valid = 1'b0;
        endcase
        if (res.valid && res.rd != 5'd0) begin
            model_regs[res.rd] = res.value; // x0 stays zero
        end
        return res;
    endfunction

    task automatic build_program();
        prog_op_t op;
        for (int n = 0; n < prog_len; n++) begin
            op.kind = kind_t'($urandom_range(3, 0));
            op.rd   = 5'($urandom_range(7, 0)); // small set, so results get reused
            op.rs1  = 5'($urandom_range(7, 0));
            op.rs2  = 5'($urandom_range(7, 0));
            op.imm  = 20'($urandom);
            prog[n] = op;
        end
        prog[0]  = '{k_addi, 5'd1, 5'd0, 5'd0, 20'h00800}; // -2048
        prog[1]  = '{k_addi, 5'd0, 5'd1, 5'd0, 20'h00123};
        prog[2]  = '{k_add, 5'd2, 5'd0, 5'd1, 20'h0};
        prog[15] = '{k_bad, 5'd5, 5'd0, 5'd0, 20'h12345};
        prog[28] = '{k_bad, 5'd6, 5'd0, 5'd1, 20'habcde};
        prog[prog_len-1] = '{k_ebreak, 5'd0, 5'd0, 5'd0, 20'h0};
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
    endtask

    task automatic drive_program();
        int       gap;
        prog_op_t extra;
        for (int n = 0; n < prog_len; n++) begin
            gap = $urandom_range(2, 0);
            repeat (gap) begin
                @(posedge clk);
                inst_valid <= 1'b0;
                inst       <= $urandom; // junk while idle
            end
            @(posedge clk);
            inst_valid <= 1'b1;
            inst       <= op_word(prog[n]);
            @(negedge clk);
            while (!inst_ready) begin
                @(negedge clk);
            end
        end
        // ebreak is taken here, then more work is offered to a halted core
        @(posedge clk);
        extra = '{k_add, 5'd7, 5'd1, 5'd1, 20'h0};
        inst <= op_word(extra);
        repeat (12) @(posedge clk);
        inst_valid <= 1'b0;
        drive_done = 1'b1;
    endtask

    task automatic watch_core();
        wb_t         exp;
        logic        halt_seen;
        logic [31:0] op_pc;
        exp       = '0;
        halt_seen = 1'b0;
        while (!drive_done) begin
            @(negedge clk);
            compare_value("wb.valid", 32'(exp.valid), 32'(wb.valid));
            if (exp.valid) begin
                compare_value("wb.rd", 32'(exp.rd), 32'(wb.rd));
                compare_value("wb.value", exp.value, wb.value);
            end
            compare_value("pc", `RV_RESET_PC + 32'(accepted) * 32'd4, pc);
            compare_value("halted", 32'(halt_seen), 32'(halted));
            compare_value("inst_ready", 32'(!halt_seen), 32'(inst_ready));
            exp = '0;
            if (inst_valid && inst_ready) begin // transfer at the coming edge
                op_pc = `RV_RESET_PC + 32'(accepted) * 32'd4;
                exp   = predict_wb(prog[accepted], op_pc);
                if (prog[accepted].kind == k_ebreak) begin
                    halt_seen = 1'b1;
                end
                accepted++;
            end
        end
    endtask

    initial begin
        cycles = 0;
        while (cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        stop_with_failure("timeout: the program did not finish within the cycle limit");
    end

    initial begin
        void'($urandom(32'h77e7af4b));
        inst_valid <= 1'b0;
        inst       <= '0;
        rst_n      <= 1'b0;
        drive_done = 1'b0;
        accepted   = 0;
        build_program();
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        compare_value("wb.valid", 32'd0, 32'(wb.valid));
        compare_value("halted", 32'd0, 32'(halted));
        compare_value("inst_ready", 32'd1, 32'(inst_ready));
        compare_value("pc", `RV_RESET_PC, pc);
        fork
            drive_program();
            watch_core();
        join
        $display("Everything OK");
        $finish;
    end

endmodule
